//--- verilog/id_pkg.sv
package id_pkg;

	localparam int unsigned XLEN       = 32;
	localparam int unsigned REG_ADDR_W = 5;

	// sequencer states.
	localparam logic FIRST_CYCLE = 1'b0;
	localparam logic MULTI_CYCLE = 1'b1;

	typedef enum logic [6:0] {
		OPCODE_LOAD   = 7'h03,
		OPCODE_OP_IMM = 7'h13,
		OPCODE_AUIPC  = 7'h17,
		OPCODE_STORE  = 7'h23,
		OPCODE_OP     = 7'h33,
		OPCODE_LUI    = 7'h37,
		OPCODE_BRANCH = 7'h63,
		OPCODE_JALR   = 7'h67,
		OPCODE_JAL    = 7'h6f
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_SRA,
		ALU_SRL,
		ALU_SLL,
		// comparisons, used by branches.
		ALU_LT,
		ALU_LTU,
		ALU_GE,
		ALU_GEU,
		ALU_EQ,
		ALU_NE,
		// set-less-than, result written to rd.
		ALU_SLT,
		ALU_SLTU
	} alu_op_e;

	typedef enum logic [1:0] {
		OP_A_REG_A,
		OP_A_CURRPC,
		OP_A_IMM_ZERO
	} op_a_sel_e;

	typedef enum logic {
		OP_B_REG_B,
		OP_B_IMM
	} op_b_sel_e;

	typedef enum logic [2:0] {
		IMM_B_I,
		IMM_B_S,
		IMM_B_B,
		IMM_B_U,
		IMM_B_J,
		IMM_B_INCR_PC
	} imm_b_sel_e;

	typedef enum logic [1:0] {
		LSU_WORD = 2'b00,
		LSU_HALF = 2'b01,
		LSU_BYTE = 2'b10
	} lsu_type_e;

	typedef struct packed {
		logic [6:0]            funct7;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [REG_ADDR_W-1:0] rd;
		opcode_e               opcode;
	} instr_r_t;

	typedef struct packed {
		logic [6:0]            imm_hi;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [4:0]            imm_lo;
		opcode_e               opcode;
	} instr_s_t;

	typedef union packed {
		instr_r_t r;
		instr_s_t s; // store view, rd field holds imm[4:0].
	} instr_word_t;

endpackage

//--- verilog/id_ctrl_if.sv
`timescale 1ns/10ps

interface id_ctrl_if import id_pkg::*; ();

	alu_op_e    alu_operator;
	op_a_sel_e  op_a_sel;
	op_b_sel_e  op_b_sel;
	imm_b_sel_e imm_b_sel;

	logic       rf_we;

	logic       lsu_req;
	logic       lsu_we;
	lsu_type_e  lsu_type;
	logic       lsu_sign_ext;

	logic       branch;
	logic       jump;
	logic       illegal;

	modport dec (
		output alu_operator, op_a_sel, op_b_sel, imm_b_sel, rf_we,
		output lsu_req, lsu_we, lsu_type, lsu_sign_ext,
		output branch, jump, illegal
	);

	modport dp (input op_a_sel, op_b_sel, imm_b_sel);

	modport seq (input rf_we, lsu_req, branch, jump, illegal);

endinterface

//--- verilog/id_decoder.sv
`timescale 1ns/10ps

module id_decoder import id_pkg::*; (
	input  instr_word_t           instr_i,
	input  logic                  instr_valid_i,
	input  logic                  first_cycle_i,
	id_ctrl_if.dec                ctrl,
	output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
	output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
	output logic [REG_ADDR_W-1:0] rf_waddr_o,
	output logic                  illegal_insn_o
);

	logic [6:0] funct7;
	logic [2:0] funct3;
	logic       rf_we;
	logic       lsu_req;
	logic       branch;
	logic       jump;
	logic       illegal;

	assign funct7 = instr_i.r.funct7;
	assign funct3 = instr_i.r.funct3;

	assign rf_raddr_a_o = instr_i.r.rs1;
	assign rf_raddr_b_o = instr_i.r.rs2;
	assign rf_waddr_o   = instr_i.r.rd;

	always_comb begin
		ctrl.alu_operator = ALU_ADD;
		ctrl.op_a_sel     = OP_A_REG_A;
		ctrl.op_b_sel     = OP_B_IMM;
		ctrl.imm_b_sel    = IMM_B_I;
		ctrl.lsu_we       = 1'b0;
		ctrl.lsu_type     = LSU_WORD;
		ctrl.lsu_sign_ext = 1'b0;
		rf_we   = 1'b0;
		lsu_req = 1'b0;
		branch  = 1'b0;
		jump    = 1'b0;
		illegal = 1'b0;

		case (instr_i.r.opcode)
			OPCODE_JAL, OPCODE_JALR: begin
				jump  = 1'b1;
				rf_we = 1'b1;
				if (instr_i.r.opcode == OPCODE_JAL) begin
					ctrl.op_a_sel  = OP_A_CURRPC;
					ctrl.imm_b_sel = IMM_B_J;
				end else if (funct3 != 3'b000) begin
					illegal = 1'b1;
				end
				// second cycle computes the link address.
				if (!first_cycle_i) begin
					ctrl.op_a_sel  = OP_A_CURRPC;
					ctrl.imm_b_sel = IMM_B_INCR_PC;
				end
			end
			OPCODE_BRANCH: begin
				branch        = 1'b1;
				ctrl.op_b_sel = OP_B_REG_B;
				case (funct3)
					3'b000:  ctrl.alu_operator = ALU_EQ;
					3'b001:  ctrl.alu_operator = ALU_NE;
					3'b100:  ctrl.alu_operator = ALU_LT;
					3'b101:  ctrl.alu_operator = ALU_GE;
					3'b110:  ctrl.alu_operator = ALU_LTU;
					3'b111:  ctrl.alu_operator = ALU_GEU;
					default: illegal = 1'b1;
				endcase
				if (!first_cycle_i) begin // taken, now the target.
					ctrl.alu_operator = ALU_ADD;
					ctrl.op_a_sel     = OP_A_CURRPC;
					ctrl.op_b_sel     = OP_B_IMM;
					ctrl.imm_b_sel    = IMM_B_B;
				end
			end
			OPCODE_LOAD: begin
				lsu_req           = 1'b1;
				rf_we             = 1'b1;
				ctrl.lsu_sign_ext = ~funct3[2];
				case (funct3[1:0])
					2'b00:   ctrl.lsu_type = LSU_BYTE;
					2'b01:   ctrl.lsu_type = LSU_HALF;
					2'b10:   ctrl.lsu_type = LSU_WORD;
					default: illegal = 1'b1;
				endcase
				if (funct3 == 3'b110) begin
					illegal = 1'b1; // no unsigned word load in rv32.
				end
			end
			OPCODE_STORE: begin
				lsu_req        = 1'b1;
				ctrl.lsu_we    = 1'b1;
				ctrl.imm_b_sel = IMM_B_S;
				case (funct3)
					3'b000:  ctrl.lsu_type = LSU_BYTE;
					3'b001:  ctrl.lsu_type = LSU_HALF;
					3'b010:  ctrl.lsu_type = LSU_WORD;
					default: illegal = 1'b1;
				endcase
			end
			OPCODE_LUI, OPCODE_AUIPC: begin
				rf_we          = 1'b1;
				ctrl.imm_b_sel = IMM_B_U;
				if (instr_i.r.opcode == OPCODE_LUI) begin
					ctrl.op_a_sel = OP_A_IMM_ZERO;
				end else begin
					ctrl.op_a_sel = OP_A_CURRPC;
				end
			end
			OPCODE_OP_IMM: begin
				rf_we = 1'b1;
				case (funct3)
					3'b000: ctrl.alu_operator = ALU_ADD;
					3'b010: ctrl.alu_operator = ALU_SLT;
					3'b011: ctrl.alu_operator = ALU_SLTU;
					3'b100: ctrl.alu_operator = ALU_XOR;
					3'b110: ctrl.alu_operator = ALU_OR;
					3'b111: ctrl.alu_operator = ALU_AND;
					3'b001: begin
						ctrl.alu_operator = ALU_SLL;
						illegal = (funct7 != 7'b0000000);
					end
					default: begin // shift right, shamt is 5 bits.
						ctrl.alu_operator = (funct7[5]) ? ALU_SRA : ALU_SRL;
						illegal = ({funct7[6], funct7[4:0]} != 6'b000000);
					end
				endcase
			end
			OPCODE_OP: begin
				rf_we         = 1'b1;
				ctrl.op_b_sel = OP_B_REG_B;
				case ({funct7, funct3})
					{7'h00, 3'b000}: ctrl.alu_operator = ALU_ADD;
					{7'h20, 3'b000}: ctrl.alu_operator = ALU_SUB;
					{7'h00, 3'b001}: ctrl.alu_operator = ALU_SLL;
					{7'h00, 3'b010}: ctrl.alu_operator = ALU_SLT;
					{7'h00, 3'b011}: ctrl.alu_operator = ALU_SLTU;
					{7'h00, 3'b100}: ctrl.alu_operator = ALU_XOR;
					{7'h00, 3'b101}: ctrl.alu_operator = ALU_SRL;
					{7'h20, 3'b101}: ctrl.alu_operator = ALU_SRA;
					{7'h00, 3'b110}: ctrl.alu_operator = ALU_OR;
					{7'h00, 3'b111}: ctrl.alu_operator = ALU_AND;
					default:         illegal = 1'b1;
				endcase
			end
			default: illegal = 1'b1;
		endcase
	end

	// an illegal word must not write, access memory or redirect.
	assign ctrl.rf_we   = rf_we & ~illegal;
	assign ctrl.lsu_req = lsu_req & ~illegal;
	assign ctrl.branch  = branch & ~illegal;
	assign ctrl.jump    = jump & ~illegal;
	assign ctrl.illegal = illegal;

	assign illegal_insn_o = instr_valid_i & illegal;

endmodule

//--- verilog/id_operand_mux.sv
`timescale 1ns/10ps

module id_operand_mux import id_pkg::*; (
	id_ctrl_if.dp           ctrl,
	input  instr_word_t     instr_i,
	input  logic [XLEN-1:0] pc_i,
	input  logic [XLEN-1:0] rf_rdata_a_i,
	input  logic [XLEN-1:0] rf_rdata_b_i,
	output logic [XLEN-1:0] alu_operand_a_o,
	output logic [XLEN-1:0] alu_operand_b_o,
	output logic [XLEN-1:0] lsu_wdata_o
);

	logic [XLEN-1:0] imm_i_type;
	logic [XLEN-1:0] imm_s_type;
	logic [XLEN-1:0] imm_b_type;
	logic [XLEN-1:0] imm_u_type;
	logic [XLEN-1:0] imm_j_type;
	logic [XLEN-1:0] imm_b;

	assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
	assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'b0};
	assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};

	always_comb begin
		case (ctrl.imm_b_sel)
			IMM_B_I:       imm_b = imm_i_type;
			IMM_B_S:       imm_b = imm_s_type;
			IMM_B_B:       imm_b = imm_b_type;
			IMM_B_U:       imm_b = imm_u_type;
			IMM_B_J:       imm_b = imm_j_type;
			IMM_B_INCR_PC: imm_b = XLEN'(4); // link address, no compressed.
			default:       imm_b = XLEN'(4);
		endcase
	end

	always_comb begin
		case (ctrl.op_a_sel)
			OP_A_REG_A:    alu_operand_a_o = rf_rdata_a_i;
			OP_A_CURRPC:   alu_operand_a_o = pc_i;
			OP_A_IMM_ZERO: alu_operand_a_o = '0;
			default:       alu_operand_a_o = pc_i;
		endcase
	end

	assign alu_operand_b_o = (ctrl.op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;

	// store data is rs2 as read.
	assign lsu_wdata_o = rf_rdata_b_i;

endmodule

//--- verilog/id_fsm.sv
`timescale 1ns/10ps

module id_fsm import id_pkg::*; (
	input  logic   clk_i,
	input  logic   rst_ni,
	id_ctrl_if.seq ctrl,
	input  logic   instr_valid_i,
	input  logic   branch_decision_i,
	input  logic   lsu_resp_valid_i,
	output logic   first_cycle_o,
	output logic   rf_we_o,
	output logic   lsu_req_o,
	output logic   pc_set_o,
	output logic   instr_done_o
);

	logic state_q;
	logic state_d;
	logic multi_cycle;
	logic last_cycle;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= FIRST_CYCLE;
		end else begin
			state_q <= state_d;
		end
	end

	// memory accesses, jumps and taken branches need a second state.
	assign multi_cycle = ~ctrl.illegal &
		(ctrl.lsu_req | ctrl.jump | (ctrl.branch & branch_decision_i));

	// jumps and branches end after one extra cycle.
	assign last_cycle = ctrl.lsu_req ? lsu_resp_valid_i : 1'b1;

	always_comb begin
		state_d       = state_q;
		first_cycle_o = 1'b0;
		rf_we_o       = 1'b0;
		lsu_req_o     = 1'b0;
		pc_set_o      = 1'b0;
		instr_done_o  = 1'b0;

		if (instr_valid_i) begin
			if (state_q == FIRST_CYCLE) begin
				first_cycle_o = 1'b1;
				lsu_req_o     = ctrl.lsu_req;
				pc_set_o      = ctrl.jump; // jump target goes out first.
				rf_we_o       = ctrl.rf_we & ~multi_cycle;
				instr_done_o  = ~multi_cycle;
				if (multi_cycle) begin
					state_d = MULTI_CYCLE;
				end
			end else begin
				pc_set_o     = ctrl.branch; // branch target.
				rf_we_o      = ctrl.rf_we & last_cycle;
				instr_done_o = last_cycle;
				if (last_cycle) begin
					state_d = FIRST_CYCLE;
				end
			end
		end
	end

	a_req_or_redirect: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(lsu_req_o && pc_set_o));

	a_we_at_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rf_we_o |-> instr_done_o);

	// a request is issued once, then held off until the response.
	a_req_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
		lsu_req_o |=> !lsu_req_o);

endmodule

//--- verilog/id_stage.sv
`timescale 1ns/10ps

module id_stage import id_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  instr_valid_i,
	input  logic [XLEN-1:0]       instr_i,
	input  logic [XLEN-1:0]       pc_i,
	input  logic [XLEN-1:0]       rf_rdata_a_i,
	input  logic [XLEN-1:0]       rf_rdata_b_i,
	input  logic                  branch_decision_i,
	input  logic                  lsu_resp_valid_i,
	output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
	output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
	output logic [REG_ADDR_W-1:0] rf_waddr_o,
	output logic                  rf_we_o,
	output alu_op_e               alu_operator_o,
	output logic [XLEN-1:0]       alu_operand_a_o,
	output logic [XLEN-1:0]       alu_operand_b_o,
	output logic                  lsu_req_o,
	output logic                  lsu_we_o,
	output lsu_type_e             lsu_type_o,
	output logic                  lsu_sign_ext_o,
	output logic [XLEN-1:0]       lsu_wdata_o,
	output logic                  pc_set_o,
	output logic                  illegal_insn_o,
	output logic                  instr_done_o
);

	id_ctrl_if ctrl ();

	logic first_cycle;

	id_decoder decoder0 (
		.instr_i        (instr_i),
		.instr_valid_i  (instr_valid_i),
		.first_cycle_i  (first_cycle),
		.ctrl           (ctrl),
		.rf_raddr_a_o   (rf_raddr_a_o),
		.rf_raddr_b_o   (rf_raddr_b_o),
		.rf_waddr_o     (rf_waddr_o),
		.illegal_insn_o (illegal_insn_o)
	);

	id_operand_mux opmux0 (
		.ctrl            (ctrl),
		.instr_i         (instr_i),
		.pc_i            (pc_i),
		.rf_rdata_a_i    (rf_rdata_a_i),
		.rf_rdata_b_i    (rf_rdata_b_i),
		.alu_operand_a_o (alu_operand_a_o),
		.alu_operand_b_o (alu_operand_b_o),
		.lsu_wdata_o     (lsu_wdata_o)
	);

	id_fsm fsm0 (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.ctrl              (ctrl),
		.instr_valid_i     (instr_valid_i),
		.branch_decision_i (branch_decision_i),
		.lsu_resp_valid_i  (lsu_resp_valid_i),
		.first_cycle_o     (first_cycle),
		.rf_we_o           (rf_we_o),
		.lsu_req_o         (lsu_req_o),
		.pc_set_o          (pc_set_o),
		.instr_done_o      (instr_done_o)
	);

	// ungated decode outputs go straight to the execute stage.
	assign alu_operator_o = ctrl.alu_operator;
	assign lsu_we_o       = ctrl.lsu_we;
	assign lsu_type_o     = ctrl.lsu_type;
	assign lsu_sign_ext_o = ctrl.lsu_sign_ext;

endmodule

//--- verification/tb_id_stage.sv
`timescale 1ns/10ps

module tb_id_stage;

	localparam int CLK_PERIOD    = 100;
	localparam int RESET_CYCLES  = 4;
	localparam int CYCLES_PER_VEC = 8;
	localparam int NUM_FIELDS    = 17;

	// column order of the stimulus file.
	localparam int F_INSTR = 0;
	localparam int F_PC    = 1;
	localparam int F_RS1   = 2;
	localparam int F_RS2   = 3;
	localparam int F_BR    = 4;
	localparam int F_OP    = 5;
	localparam int F_OPA   = 6;
	localparam int F_OPB   = 7;
	localparam int F_RD    = 8;
	localparam int F_WE    = 9;
	localparam int F_PCSET = 10; // cycle of the redirect, 0 for none.
	localparam int F_REQ   = 11;
	localparam int F_LSWE  = 12;
	localparam int F_TYPE  = 13;
	localparam int F_SEXT  = 14;
	localparam int F_ILL   = 15;
	localparam int F_LEN   = 16; // cycles when no memory access.

	typedef logic [NUM_FIELDS-1:0][31:0] vec_t;

	logic        clk_i;
	logic        rst_ni;
	logic        instr_valid_i;
	logic [31:0] instr_i;
	logic [31:0] pc_i;
	logic [31:0] rf_rdata_a_i;
	logic [31:0] rf_rdata_b_i;
	logic        branch_decision_i;
	logic        lsu_resp_valid_i;
	logic [4:0]  rf_raddr_a_o;
	logic [4:0]  rf_raddr_b_o;
	logic [4:0]  rf_waddr_o;
	logic        rf_we_o;
	logic [4:0]  alu_operator_o;
	logic [31:0] alu_operand_a_o;
	logic [31:0] alu_operand_b_o;
	logic        lsu_req_o;
	logic        lsu_we_o;
	logic [1:0]  lsu_type_o;
	logic        lsu_sign_ext_o;
	logic [31:0] lsu_wdata_o;
	logic        pc_set_o;
	logic        illegal_insn_o;
	logic        instr_done_o;

	vec_t        vecs[$];
	int          cur_vec = -1;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;
	logic [31:0] rand_state;

	id_stage dut0 (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.instr_valid_i     (instr_valid_i),
		.instr_i           (instr_i),
		.pc_i              (pc_i),
		.rf_rdata_a_i      (rf_rdata_a_i),
		.rf_rdata_b_i      (rf_rdata_b_i),
		.branch_decision_i (branch_decision_i),
		.lsu_resp_valid_i  (lsu_resp_valid_i),
		.rf_raddr_a_o      (rf_raddr_a_o),
		.rf_raddr_b_o      (rf_raddr_b_o),
		.rf_waddr_o        (rf_waddr_o),
		.rf_we_o           (rf_we_o),
		.alu_operator_o    (alu_operator_o),
		.alu_operand_a_o   (alu_operand_a_o),
		.alu_operand_b_o   (alu_operand_b_o),
		.lsu_req_o         (lsu_req_o),
		.lsu_we_o          (lsu_we_o),
		.lsu_type_o        (lsu_type_o),
		.lsu_sign_ext_o    (lsu_sign_ext_o),
		.lsu_wdata_o       (lsu_wdata_o),
		.pc_set_o          (pc_set_o),
		.illegal_insn_o    (illegal_insn_o),
		.instr_done_o      (instr_done_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD/2) clk_i = ~clk_i;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: vector %0d %s is %h, expected %h",
				$time, cur_vec, what, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic stop_with_error(input string why);
		$display("error at %0t: %s", $time, why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic load_vectors();
		int    fd;
		int    cnt;
		string line;
		vec_t  v;
		fd = $fopen("verification/id_stimulus.txt", "r");
		if (fd == 0) begin
			stop_with_error("cannot open the stimulus file");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line[0] != "#") begin
				cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
					v[9], v[10], v[11], v[12], v[13], v[14], v[15], v[16]);
				if (cnt != NUM_FIELDS) begin
					stop_with_error($sformatf("bad stimulus line: %s", line));
				end
				vecs.push_back(v);
			end
		end
		$fclose(fd);
		if (vecs.size() == 0) begin
			stop_with_error("the stimulus file holds no vectors");
		end
	endtask

	// one instruction, held until done, then one idle cycle.
	task automatic run_vector(input int n);
		vec_t v;
		int   cyc;
		int   resp_wait;
		logic exp_done;
		v = vecs[n];
		cur_vec = n;
		cyc = 0;
		resp_wait = 0;
		exp_done = 1'b0;
		instr_valid_i     = 1'b1;
		instr_i           = v[F_INSTR];
		pc_i              = v[F_PC];
		rf_rdata_a_i      = v[F_RS1];
		rf_rdata_b_i      = v[F_RS2];
		branch_decision_i = v[F_BR][0];
		while (!exp_done) begin
			@(posedge clk_i);
			cyc++;
			// memory accesses end on the response, the rest after a fixed count.
			exp_done = v[F_REQ][0] ? lsu_resp_valid_i : (cyc == v[F_LEN]);
			check_equal("instr_done", instr_done_o, exp_done);
			check_equal("pc_set", pc_set_o, v[F_PCSET] == cyc);
			check_equal("lsu_req", lsu_req_o, v[F_REQ][0] && cyc == 1);
			check_equal("rf_we", rf_we_o, v[F_WE][0] && exp_done);
			if (cyc == 1) begin
				check_equal("illegal", illegal_insn_o, v[F_ILL]);
				check_equal("raddr_a", rf_raddr_a_o, v[F_INSTR][19:15]);
				check_equal("raddr_b", rf_raddr_b_o, v[F_INSTR][24:20]);
				check_equal("waddr", rf_waddr_o, v[F_RD]);
				if (v[F_REQ][0]) begin
					check_equal("lsu_we", lsu_we_o, v[F_LSWE]);
					check_equal("lsu_type", lsu_type_o, v[F_TYPE]);
					if (v[F_LSWE][0]) begin
						check_equal("lsu_wdata", lsu_wdata_o, v[F_RS2]);
					end else begin
						check_equal("lsu_sign_ext", lsu_sign_ext_o, v[F_SEXT]);
					end
					rand_state = lcg_next(rand_state);
					resp_wait = 1 + int'(rand_state[31:30]); // 1 to 4 cycles.
				end
			end
			if (exp_done && !v[F_ILL][0]) begin
				check_equal("alu_operator", alu_operator_o, v[F_OP]);
				check_equal("operand_a", alu_operand_a_o, v[F_OPA]);
				check_equal("operand_b", alu_operand_b_o, v[F_OPB]);
			end
			@(negedge clk_i);
			lsu_resp_valid_i = 1'b0;
			if (resp_wait > 0) begin
				resp_wait--;
				if (resp_wait == 0) begin
					lsu_resp_valid_i = 1'b1;
				end
			end
		end
		instr_valid_i = 1'b0;
		@(posedge clk_i);
		check_equal("idle instr_done", instr_done_o, 1'b0);
		check_equal("idle rf_we", rf_we_o, 1'b0);
		check_equal("idle lsu_req", lsu_req_o, 1'b0);
		check_equal("idle pc_set", pc_set_o, 1'b0);
		@(negedge clk_i);
	endtask

	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("sim failed");
			$fatal(1);
		end
	end

	initial begin
		int n;
		rst_ni            = 1'b0;
		instr_valid_i     = 1'b0;
		instr_i           = '0;
		pc_i              = '0;
		rf_rdata_a_i      = '0;
		rf_rdata_b_i      = '0;
		branch_decision_i = 1'b0;
		lsu_resp_valid_i  = 1'b0;
		rand_state        = 32'hb2d6_8046;
		load_vectors();
		cycle_limit = vecs.size() * CYCLES_PER_VEC + RESET_CYCLES;
		repeat (RESET_CYCLES) @(negedge clk_i);
		rst_ni = 1'b1;
		for (n = 0; n < vecs.size(); n++) begin
			run_vector(n);
		end
		$display("sim passed");
		$finish;
	end

endmodule

//--- verification/id_stimulus.txt
# instr pc rs1 rs2 br | alu_op opa opb rd we pcset req lswe type sext ill len (hex)
# opa/opb at done; pcset is the cycle of the redirect; len 0 means done on response.
002081B3 00000100 12345678 0BADF00D 0 0 12345678 0BADF00D 03 1 0 0 0 0 0 0 1
407302B3 00000104 00000010 00000003 0 1 00000010 00000003 05 1 0 0 0 0 0 0 1
40A4D433 00000108 80000000 0000001F 0 5 80000000 0000001F 08 1 0 0 0 0 0 0 1
FFF10093 0000010C 00000042 DEADBEEF 0 0 00000042 FFFFFFFF 01 1 0 0 0 0 0 0 1
7FF2B213 00000110 00000800 00000000 0 F 00000800 000007FF 04 1 0 0 0 0 0 0 1
4033D313 00000114 F0000000 00000000 0 5 F0000000 00000403 06 1 0 0 0 0 0 0 1
123453B7 00000118 CAFEF00D 00000000 0 0 00000000 12345000 07 1 0 0 0 0 0 0 1
FFFFF497 0000011C 00000000 00000000 0 0 0000011C FFFFF000 09 1 0 0 0 0 0 0 1
00208863 00000120 00000005 00000005 1 0 00000120 00000010 10 0 2 0 0 0 0 0 2
FE419CE3 00000124 00000007 00000007 0 D 00000007 00000007 19 0 0 0 0 0 0 0 1
FE62ECE3 00000128 00000001 00000002 1 0 00000128 FFFFFFF8 19 0 2 0 0 0 0 0 2
001000EF 0000012C 00000000 00000000 0 0 0000012C 00000004 01 1 1 0 0 0 0 0 2
00C302E7 00000130 00004000 00000000 0 0 00000130 00000004 05 1 1 0 0 0 0 0 2
00812503 00000134 00001000 00000000 0 0 00001000 00000008 0A 1 0 1 0 0 1 0 0
FFF1C583 00000138 00002001 00000000 0 0 00002001 FFFFFFFF 0B 1 0 1 0 2 0 0 0
00221603 0000013C 00003000 00000000 0 0 00003000 00000002 0C 1 0 1 0 1 1 0 0
00742A23 00000140 00004000 A5A5A5A5 0 0 00004000 00000014 14 0 0 1 1 0 0 0 0
FE950E23 00000144 00005004 0000005A 0 0 00005004 FFFFFFFC 1C 0 0 1 1 2 0 0 0
7E111823 00000148 00006000 00001234 0 0 00006000 000007F0 10 0 0 1 1 1 0 0 0
0000007F 0000014C 00000000 00000000 0 0 00000000 00000000 00 0 0 0 0 0 0 1 1
02208133 00000150 00000001 00000002 0 0 00000000 00000000 02 0 0 0 0 0 0 1 1
00013183 00000154 00000003 00000004 0 0 00000000 00000000 03 0 0 0 0 0 0 1 1
000010E7 00000158 00000005 00000006 0 0 00000000 00000000 01 0 0 0 0 0 0 1 1
0020A063 0000015C 00000007 00000008 1 0 00000000 00000000 00 0 0 0 0 0 0 1 1
02009093 00000160 00000009 0000000A 0 0 00000000 00000000 01 0 0 0 0 0 0 1 1

//--- filelist.f
verilog/id_pkg.sv
verilog/id_ctrl_if.sv
verilog/id_decoder.sv
verilog/id_operand_mux.sv
verilog/id_fsm.sv
verilog/id_stage.sv
verification/tb_id_stage.sv
